// ==== design/rcn_pkg.sv ====
/*
 * rcn ring definitions shared by the master, buffer, slave and testbench
 * ring flit, buffered host request and host response formats
 */

package rcn_pkg;

  ////////////////////////////////////////
  // field widths
  ////////////////////////////////////////

  localparam int id_w   = 6;
  localparam int addr_w = 22;
  localparam int data_w = 32;
  localparam int seq_w  = 2;
  // one enable per data byte
  localparam int mask_w = data_w / 8;

  ////////////////////////////////////////
  // ring word, 69 bits
  ////////////////////////////////////////

  typedef struct packed {
    logic              valid;
    logic              pending;
    logic              wr;
    logic [id_w-1:0]   id;
    logic [mask_w-1:0] mask;
    logic [addr_w-1:0] addr;
    logic [seq_w-1:0]  seq;
    logic [data_w-1:0] data;
  } rcn_flit_t;

  // host request as held in the buffer, word address only
  typedef struct packed {
    logic [seq_w-1:0]  seq;
    logic              wr;
    logic [mask_w-1:0] mask;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } rcn_req_t;

  // response back to the host, byte address
  typedef struct packed {
    logic [seq_w-1:0]  seq;
    logic [mask_w-1:0] mask;
    logic [addr_w+1:0] addr;
    logic [data_w-1:0] data;
  } rcn_rsp_t;

endpackage

// ==== design/rcn_master.sv ====
/*
 * rcn ring master node
 * inserts requests into free slots and takes its own responses off the ring
 */

`timescale 1ns/100ps

module rcn_master #(
  parameter int unsigned master_id = 0
) (
  input  logic               clk,
  input  logic               rst,
  input  rcn_pkg::rcn_flit_t rcn_in,
  input  logic               req_vld,
  input  rcn_pkg::rcn_req_t  req,
  output rcn_pkg::rcn_flit_t rcn_out,
  output logic               req_busy,
  output logic               rdone,
  output logic               wdone,
  output rcn_pkg::rcn_rsp_t  rsp
);

  logic               own_rsp;
  logic               take_req;
  rcn_pkg::rcn_flit_t req_flit;
  rcn_pkg::rcn_flit_t nxt_out;

  // a completed request coming home
  assign own_rsp = rcn_in.valid && !rcn_in.pending &&
                   (rcn_in.id == rcn_pkg::id_w'(master_id));

  // slot is usable if empty or freed by the response just removed
  assign req_busy = rcn_in.valid && !own_rsp;
  assign take_req = req_vld && !req_busy;

  ////////////////////////////////////////
  // insertion
  ////////////////////////////////////////

  always_comb begin
    req_flit         = '0;
    req_flit.valid   = 1'b1;
    req_flit.pending = 1'b1;
    req_flit.wr      = req.wr;
    req_flit.id      = rcn_pkg::id_w'(master_id);
    req_flit.mask    = req.mask;
    req_flit.addr    = req.addr;
    req_flit.seq     = req.seq;
    req_flit.data    = req.wdata;
  end

  always_comb begin
    if (take_req)
      nxt_out = req_flit;
    else if (own_rsp)
      nxt_out = '0;
    else
      nxt_out = rcn_in;
  end

  // one cycle per hop
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      rcn_out <= '0;
    else
      rcn_out <= nxt_out;
  end

  ////////////////////////////////////////
  // response capture
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdone <= 1'b0;
      wdone <= 1'b0;
    end else begin
      rdone <= own_rsp && !rcn_in.wr;
      wdone <= own_rsp && rcn_in.wr;
    end
  end

  always_ff @(posedge clk) begin
    if (own_rsp) begin
      rsp.seq  <= rcn_in.seq;
      rsp.mask <= rcn_in.mask;
      rsp.addr <= {rcn_in.addr, 2'b00};
      rsp.data <= rcn_in.data;
    end
  end

endmodule

// ==== design/rcn_slave_ram.sv ====
/*
 * rcn ring slave with a word memory behind one address window
 * services pending requests in place and returns them as responses
 */

`timescale 1ns/100ps

module rcn_slave_ram #(
  parameter int unsigned addr_base = 0,
  parameter int unsigned ram_words = 256
) (
  input  logic               clk,
  input  logic               rst,
  input  rcn_pkg::rcn_flit_t rcn_in,
  output rcn_pkg::rcn_flit_t rcn_out
);

  // word index bits and the window select bits above them
  localparam int idx_w = $clog2(ram_words);
  localparam int hi_w  = rcn_pkg::addr_w - idx_w;

  logic [rcn_pkg::data_w-1:0] mem [ram_words];
  logic [idx_w-1:0]           idx;
  logic                       hit;
  logic [rcn_pkg::data_w-1:0] rd_word;

  assign idx     = rcn_in.addr[idx_w-1:0];
  assign hit     = rcn_in.valid && rcn_in.pending &&
                   (rcn_in.addr[rcn_pkg::addr_w-1:idx_w] == hi_w'(addr_base));
  assign rd_word = mem[idx];

  ////////////////////////////////////////
  // memory, byte masked write
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (hit && rcn_in.wr) begin
      for (int b = 0; b < rcn_pkg::mask_w; b++) begin
        if (rcn_in.mask[b])
          mem[idx][8*b +: 8] <= rcn_in.data[8*b +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // ring output
  ////////////////////////////////////////

  // writes echo their data, reads carry the stored word
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rcn_out <= '0;
    end else begin
      rcn_out <= rcn_in;
      if (hit) begin
        rcn_out.pending <= 1'b0;
        if (!rcn_in.wr)
          rcn_out.data <= rd_word;
      end
    end
  end

endmodule

// ==== design/rcn_master_buf.sv ====
/*
 * rcn master with a circular request buffer in front of it
 * reports busy when full and pulses issue as each request enters the ring
 */

`timescale 1ns/100ps

module rcn_master_buf #(
  parameter int unsigned master_id = 0,
  parameter int unsigned depth     = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cs,
  input  logic                          wr,
  input  logic [rcn_pkg::seq_w-1:0]     seq,
  input  logic [rcn_pkg::mask_w-1:0]    mask,
  input  logic [rcn_pkg::addr_w+1:0]    addr,
  input  logic [rcn_pkg::data_w-1:0]    wdata,
  input  rcn_pkg::rcn_flit_t            rcn_in,
  output logic                          busy,
  output logic                          issue,
  output logic [rcn_pkg::seq_w-1:0]     iss_seq,
  output logic                          rdone,
  output logic                          wdone,
  output rcn_pkg::rcn_rsp_t             rsp,
  output rcn_pkg::rcn_flit_t            rcn_out
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  rcn_pkg::rcn_req_t req_mem [depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  req_cnt;
  logic              push;
  logic              pop;
  logic              req_vld;
  logic              req_busy;
  rcn_pkg::rcn_req_t req_head;

  assign busy     = (req_cnt == cnt_w'(depth));
  assign push     = cs && !busy;
  assign req_vld  = (req_cnt != '0);
  assign pop      = req_vld && !req_busy;
  assign req_head = req_mem[rd_ptr];

  // the pop itself is the issue event
  assign issue   = pop;
  assign iss_seq = req_head.seq;

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      req_cnt <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (push && !pop)
        req_cnt <= req_cnt + 1'b1;
      else if (pop && !push)
        req_cnt <= req_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      req_mem[wr_ptr] <= '{seq: seq, wr: wr, mask: mask,
                           addr: addr[rcn_pkg::addr_w+1:2], wdata: wdata};
  end

  rcn_master #(
    .master_id(master_id)
  ) u_master (
    .clk     (clk),
    .rst     (rst),
    .rcn_in  (rcn_in),
    .req_vld (req_vld),
    .req     (req_head),
    .rcn_out (rcn_out),
    .req_busy(req_busy),
    .rdone   (rdone),
    .wdone   (wdone),
    .rsp     (rsp)
  );

endmodule

// ==== design/rcn_ring_top.sv ====
/*
 * two-node rcn ring, buffered master plus memory slave
 */

`timescale 1ns/100ps

module rcn_ring_top #(
  parameter int unsigned master_id = 0,
  parameter int unsigned depth     = 8,
  parameter int unsigned addr_base = 1,
  parameter int unsigned ram_words = 256
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cs,
  input  logic                       wr,
  input  logic [rcn_pkg::seq_w-1:0]  seq,
  input  logic [rcn_pkg::mask_w-1:0] mask,
  input  logic [rcn_pkg::addr_w+1:0] addr,
  input  logic [rcn_pkg::data_w-1:0] wdata,
  output logic                       busy,
  output logic                       issue,
  output logic [rcn_pkg::seq_w-1:0]  iss_seq,
  output logic                       rdone,
  output logic                       wdone,
  output rcn_pkg::rcn_rsp_t          rsp
);

  // master to slave, slave back to master
  rcn_pkg::rcn_flit_t ring_fwd;
  rcn_pkg::rcn_flit_t ring_ret;

  rcn_master_buf #(
    .master_id(master_id),
    .depth    (depth)
  ) u_master_buf (
    .clk    (clk),
    .rst    (rst),
    .cs     (cs),
    .wr     (wr),
    .seq    (seq),
    .mask   (mask),
    .addr   (addr),
    .wdata  (wdata),
    .rcn_in (ring_ret),
    .busy   (busy),
    .issue  (issue),
    .iss_seq(iss_seq),
    .rdone  (rdone),
    .wdone  (wdone),
    .rsp    (rsp),
    .rcn_out(ring_fwd)
  );

  rcn_slave_ram #(
    .addr_base(addr_base),
    .ram_words(ram_words)
  ) u_slave_ram (
    .clk    (clk),
    .rst    (rst),
    .rcn_in (ring_fwd),
    .rcn_out(ring_ret)
  );

endmodule

// ==== test/rcn_ring_tb.sv ====
/*
 * rcn ring testbench that drives host requests into the two-node ring
 * and checks every response against a memory reference model
 */

`timescale 1ns/100ps

module rcn_ring_tb;

  // single entry buffer so that a held cs actually sees busy
  localparam int unsigned depth     = 1;
  localparam int unsigned addr_base = 1;
  localparam int unsigned ram_words = 256;
  localparam int          idx_w     = $clog2(ram_words);

  logic                       clk;
  logic                       rst;
  logic                       cs;
  logic                       wr;
  logic [rcn_pkg::seq_w-1:0]  seq;
  logic [rcn_pkg::mask_w-1:0] mask;
  logic [rcn_pkg::addr_w+1:0] addr;
  logic [rcn_pkg::data_w-1:0] wdata;
  logic                       busy;
  logic                       issue;
  logic [rcn_pkg::seq_w-1:0]  iss_seq;
  logic                       rdone;
  logic                       wdone;
  rcn_pkg::rcn_rsp_t          rsp;

  logic [rcn_pkg::data_w-1:0] model_mem [ram_words];
  rcn_pkg::rcn_rsp_t          exp_q [$];
  logic                       exp_wr_q [$];
  logic [rcn_pkg::seq_w-1:0]  pend_seq_q [$];
  logic [rcn_pkg::seq_w-1:0]  iss_seq_q [$];
  int                         iss_cyc_q [$];
  int                         idx_list [$];
  int                         cyc;
  int                         held;
  int                         n_acc;
  int                         n_rsp;
  int                         errors;
  int                         checks;
  logic                       seen_cs;
  logic [rcn_pkg::seq_w-1:0]  tag;

  rcn_ring_top #(
    .master_id(0),
    .depth    (depth),
    .addr_base(addr_base),
    .ram_words(ram_words)
  ) dut (
    .clk(clk), .rst(rst), .cs(cs), .wr(wr), .seq(seq), .mask(mask), .addr(addr),
    .wdata(wdata), .busy(busy), .issue(issue), .iss_seq(iss_seq), .rdone(rdone),
    .wdone(wdone), .rsp(rsp)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // reference model and helpers
  ////////////////////////////////////////

  // expected response data with the memory updated in request order
  function automatic logic [rcn_pkg::data_w-1:0] ref_access(input logic wr_i,
      input logic [rcn_pkg::mask_w-1:0] mask_i, input int idx_i,
      input logic [rcn_pkg::data_w-1:0] data_i);
    logic [rcn_pkg::data_w-1:0] word;
    int b;
    word = model_mem[idx_i];
    if (!wr_i)
      return word;
    for (b = 0; b < rcn_pkg::mask_w; b++) begin
      if (mask_i[b])
        word[8*b +: 8] = data_i[8*b +: 8];
    end
    model_mem[idx_i] = word;
    return data_i;
  endfunction

  // byte address of a word inside the slave window
  function automatic logic [rcn_pkg::addr_w+1:0] byte_addr(input int idx_i);
    logic [rcn_pkg::addr_w-1:0] word_addr;
    word_addr = (rcn_pkg::addr_w'(addr_base) << idx_w) | rcn_pkg::addr_w'(idx_i);
    return {word_addr, 2'b00};
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic drive_req(input logic wr_i, input logic [rcn_pkg::mask_w-1:0] mask_i,
      input int idx_i, input logic [rcn_pkg::data_w-1:0] data_i);
    cs    <= 1'b1;
    wr    <= wr_i;
    seq   <= tag;
    mask  <= mask_i;
    addr  <= byte_addr(idx_i);
    wdata <= data_i;
    tag = tag + 1'b1;
  endtask

  // holds the request until an edge with busy low takes it
  task automatic send_req(input logic wr_i, input logic [rcn_pkg::mask_w-1:0] mask_i,
      input int idx_i, input logic [rcn_pkg::data_w-1:0] data_i);
    int waited;
    waited = 0;
    drive_req(wr_i, mask_i, idx_i, data_i);
    @(posedge clk);
    while (busy && waited < 50) begin
      waited++;
      @(posedge clk);
    end
    if (busy) begin
      errors++;
      $display("request not accepted before timeout");
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    cs <= 1'b0;
    @(negedge clk);
    while ((exp_q.size() != 0 || held != 0) && waited < 100) begin
      waited++;
      @(negedge clk);
    end
    if (exp_q.size() != 0 || held != 0) begin
      errors++;
      $display("no response before timeout");
    end
    @(posedge clk);
  endtask

  ////////////////////////////////////////
  // monitor and checker
  ////////////////////////////////////////

  always @(posedge clk) begin
    rcn_pkg::rcn_rsp_t exp_rsp;
    logic exp_wr;
    logic [rcn_pkg::seq_w-1:0] exp_seq;
    cyc++;
    if (!rst) begin
      if (!seen_cs) begin
        compare("reset busy", 0, busy);
        compare("reset issue", 0, issue);
        compare("reset rdone", 0, rdone);
        compare("reset wdone", 0, wdone);
      end
      compare("busy flag", held == depth, busy);
      if (rdone || wdone) begin
        n_rsp++;
        if (rdone && wdone) begin
          errors++;
          $display("rdone and wdone high in the same cycle");
        end
        if (exp_q.size() == 0 || iss_cyc_q.size() == 0) begin
          errors++;
          $display("response arrived with no request outstanding");
        end else begin
          exp_rsp = exp_q.pop_front();
          exp_wr  = exp_wr_q.pop_front();
          compare("response kind", exp_wr, wdone);
          compare("response fields", exp_rsp, rsp);
          compare("issue to response", 3, cyc - iss_cyc_q.pop_front());
          compare("response seq", iss_seq_q.pop_front(), rsp.seq);
        end
      end
      // older requests leave the buffer before newer ones are counted
      if (issue) begin
        if (pend_seq_q.size() == 0) begin
          errors++;
          $display("issue with no request in the buffer");
        end else begin
          exp_seq = pend_seq_q.pop_front();
          compare("issue seq", exp_seq, iss_seq);
          held--;
          iss_cyc_q.push_back(cyc);
          iss_seq_q.push_back(exp_seq);
        end
      end
      if (cs && !busy) begin
        exp_rsp.seq  = seq;
        exp_rsp.mask = mask;
        exp_rsp.addr = addr;
        exp_rsp.data = ref_access(wr, mask, addr[idx_w+1:2], wdata);
        exp_q.push_back(exp_rsp);
        exp_wr_q.push_back(wr);
        pend_seq_q.push_back(seq);
        held++;
        n_acc++;
      end
      if (cs)
        seen_cs = 1'b1;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    int i;
    int n;
    int pick;
    void'($urandom(32'hb06a));
    clk = 1'b0;
    rst = 1'b1;
    cs = 1'b0;
    wr = 1'b0;
    seq = '0;
    mask = '0;
    addr = '0;
    wdata = '0;
    tag = '0;
    seen_cs = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    cs  <= 1'b0;
    repeat (4) @(posedge clk);

    // full word writes followed by reads of the same words
    for (i = 0; i < 16; i++) begin
      pick = $urandom_range(ram_words - 1);
      idx_list.push_back(pick);
      send_req(1'b1, 4'hf, pick, $urandom);
    end
    for (i = 0; i < 16; i++)
      send_req(1'b0, 4'hf, idx_list[$urandom_range(idx_list.size() - 1)], '0);
    wait_drain();

    // partial writes merge into known words
    for (i = 0; i < 12; i++)
      send_req(1'b1, $urandom_range(14, 1), idx_list[$urandom_range(idx_list.size() - 1)],
               $urandom);
    for (i = 0; i < 12; i++)
      send_req(1'b0, 4'hf, idx_list[$urandom_range(idx_list.size() - 1)], '0);
    wait_drain();

    // long burst with cs held high and refused cycles dropped by the host
    n = 60 + $urandom_range(40);
    for (i = 0; i < n; i++) begin
      pick = idx_list[$urandom_range(idx_list.size() - 1)];
      drive_req($urandom_range(1), $urandom_range(15), pick, $urandom);
      @(posedge clk);
    end
    wait_drain();

    compare("response count", n_acc, n_rsp);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== src.f ====
design/rcn_pkg.sv
design/rcn_master.sv
design/rcn_slave_ram.sv
design/rcn_master_buf.sv
design/rcn_ring_top.sv
test/rcn_ring_tb.sv

// ==== Bender.yml ====
package:
  name: rcn_ring

sources:
  # design, package first
  - files:
      - design/rcn_pkg.sv
      - design/rcn_master.sv
      - design/rcn_slave_ram.sv
      - design/rcn_master_buf.sv
      - design/rcn_ring_top.sv
  # testbench
  - target: test
    files:
      - test/rcn_ring_tb.sv
